// ==== compile.f ====
+incdir+dv
logic/video_dac_pkg.sv
logic/pixel_source_mux.sv
logic/palette_ram.sv
logic/pwm_dither.sv
logic/video_dac_top.sv
dv/video_dac_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the colour stage testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f compile.f --top-module video_dac_tb \
	-Mdir "$build_dir" -o video_dac_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

"./$build_dir/video_dac_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log_file"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi

// ==== dv/video_dac_model.svh ====
// reference model of the colour stage; include it inside the testbench after the DUT input signals
`ifndef VIDEO_DAC_MODEL_SVH
`define VIDEO_DAC_MODEL_SVH

// palette shadow, written on the same edges as the DUT
logic [PAL_DATA_W-1:0] shadow [256];
logic [7:0]            model_hold;
logic [1:0]            model_cnt;
// index sampled at the last edge, read by the RAM at the coming edge
logic [7:0]            last_index;
// expected dac after the next two edges
dac_pair_t             exp_q [$];

// pattern bit set lifts the code by one, except at full scale
function automatic logic [1:0] dither_code(input logic [1:0] code, input logic [2:0] inten,
	input logic [2:0] bit_num);
	logic [7:0] pat;
	pat = PWM_PATTERN[inten];
	if (pat[bit_num] && code != 2'd3)
		return code + 2'd1;
	else
		return code;
endfunction

function automatic dac_pair_t expected_pair(input palette_word_t w, input logic [1:0] phase);
	dac_pair_t p;
	p.red0 = dither_code(w.cred, w.ired, {phase, 1'b0});
	p.grn0 = dither_code(w.cgrn, w.igrn, {phase, 1'b0});
	p.blu0 = dither_code(w.cblu, w.iblu, {phase, 1'b0});
	p.red1 = dither_code(w.cred, w.ired, {phase, 1'b1});
	p.grn1 = dither_code(w.cgrn, w.igrn, {phase, 1'b1});
	p.blu1 = dither_code(w.cblu, w.iblu, {phase, 1'b1});
	return p;
endfunction

// hires keeps one nibble and points into entries 240 to 255
function automatic logic [7:0] index_of(input logic [7:0] code, input logic hires,
	input logic low_nib);
	if (!hires)
		return code;
	else if (low_nib)
		return {4'hf, code[3:0]};
	else
		return {4'hf, code[7:4]};
endfunction

task automatic model_reset();
	model_hold = '0;
	model_cnt  = '0;
	last_index = '0;
	exp_q.delete();
	// reset pipeline carries blank, so the first two outputs are zero
	exp_q.push_back('0);
	exp_q.push_back('0);
endtask

// one active clock edge, inputs as sampled at that edge
task automatic model_edge();
	logic [7:0]    code;
	logic          hires;
	logic          low_nib;
	logic          blank;
	logic [1:0]    later_cnt;
	logic [1:0]    phase;
	palette_word_t word;
	// a write at this edge is seen by the read one edge later
	if (pal_wr.we)
		shadow[pal_wr.addr] = pal_wr.data;
	code    = (mode == SCAN_VGA) ? vga_pix : model_hold;
	hires   = (mode == SCAN_VGA) ? vga_hires : tv_hires;
	low_nib = (mode == SCAN_VGA) ? nib_sel[0] : nib_sel[1];
	blank   = (mode == SCAN_VGA) ? vga_blank : tv_blank;
	last_index = index_of(code, hires, low_nib);
	word = blank ? '0 : palette_word_t'(shadow[last_index]);
	// counter value seen by the output register two edges on
	later_cnt = model_cnt + 2'd2;
	phase = {(mode == SCAN_VGA) ? vga_line : later_cnt[1], later_cnt[0]};
	exp_q.push_back(expected_pair(word, phase));
	if (c3)
		model_hold = tv_pix;
	model_cnt = model_cnt + 2'd1;
endtask

`endif

// ==== dv/video_dac_tb.sv ====
// random traffic of about 4000 cycles; every palette entry is written before unblanked pixels show
`timescale 1ns/1ps

module video_dac_tb
	import video_dac_pkg::*;
();

	localparam int RESET_CYCLES  = 10;
	localparam int FILL_CYCLES   = 256;
	localparam int MIX_CYCLES    = 600;
	localparam int HIRES_CYCLES  = 400;
	localparam int STROBE_CYCLES = 500;
	localparam int BLANK_CYCLES  = 300;
	localparam int LOAD_CYCLES   = 32;
	localparam int SWEEP_CYCLES  = 600;
	localparam int FLUSH_CYCLES  = 2;
	localparam int TOTAL_CYCLES  = RESET_CYCLES + FILL_CYCLES + MIX_CYCLES + 2 * HIRES_CYCLES
		+ STROBE_CYCLES + 2 * BLANK_CYCLES + LOAD_CYCLES + 2 * SWEEP_CYCLES + FLUSH_CYCLES;
	// a quarter of margin over the expected run length
	localparam int MAX_CYCLES = TOTAL_CYCLES + TOTAL_CYCLES / 4;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        c3;
	scan_mode_e  mode;
	logic [7:0]  tv_pix;
	logic [7:0]  vga_pix;
	logic        tv_blank;
	logic        vga_blank;
	logic        vga_line;
	logic [1:0]  nib_sel;
	logic        tv_hires;
	logic        vga_hires;
	palette_wr_t pal_wr;
	dac_pair_t   dac;

	// stimulus shape for the running phase
	scan_mode_e  cfg_mode;
	logic        cfg_hires;
	int          cfg_blank_pct;
	int          cfg_wr_pct;
	int          cfg_c3_pct;
	logic [7:0]  cfg_code_mask;
	int          fill_left = 0;
	logic [7:0]  fill_addr;
	logic        fill_sweep;
	int          cycle_count = 0;

	`include "video_dac_model.svh"

	video_dac_top u_video_dac_top
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.c3        (c3),
		.mode      (mode),
		.tv_pix    (tv_pix),
		.vga_pix   (vga_pix),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.vga_line  (vga_line),
		.nib_sel   (nib_sel),
		.tv_hires  (tv_hires),
		.vga_hires (vga_hires),
		.pal_wr    (pal_wr),
		.dac       (dac)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	function automatic bit chance(input int pct);
		return int'($urandom() % 100) < pct;
	endfunction

	// every channel walks all 32 code and intensity pairs over addresses 0 to 31
	function automatic palette_word_t sweep_word(input logic [7:0] addr);
		palette_word_t w;
		w.cred = addr[1:0];
		w.ired = addr[4:2];
		w.cgrn = addr[1:0] + 2'd1;
		w.igrn = ~addr[4:2];
		w.cblu = addr[1:0] ^ 2'd2;
		w.iblu = addr[4:2] + 3'd3;
		return w;
	endfunction

	task automatic check_value(input string name, input logic [11:0] expected,
		input logic [11:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic drive_inputs();
		c3        = chance(cfg_c3_pct);
		mode      = cfg_mode;
		tv_pix    = 8'($urandom()) & cfg_code_mask;
		vga_pix   = 8'($urandom()) & cfg_code_mask;
		tv_blank  = chance(cfg_blank_pct);
		vga_blank = chance(cfg_blank_pct);
		vga_line  = 1'($urandom());
		nib_sel   = 2'($urandom());
		tv_hires  = cfg_hires;
		vga_hires = cfg_hires;
		pal_wr.we   = 1'b0;
		pal_wr.addr = 8'($urandom());
		pal_wr.data = 15'($urandom());
		if (fill_left > 0)
		begin
			pal_wr.we   = 1'b1;
			pal_wr.addr = fill_addr;
			if (fill_sweep)
				pal_wr.data = sweep_word(fill_addr);
			fill_addr = fill_addr + 8'd1;
			fill_left--;
		end
		else if (chance(cfg_wr_pct))
		begin
			pal_wr.we = 1'b1;
			// hit the entry that the RAM reads at the same edge
			if (chance(25))
				pal_wr.addr = last_index;
		end
	endtask

	task automatic clock_cycle();
		dac_pair_t expected;
		@(posedge clk);
		#1;
		if (rst_n)
		begin
			expected = exp_q.pop_front();
			check_value("dac", expected, dac);
			model_edge();
		end
		#4;
		drive_inputs();
	endtask

	task automatic run_cycles(input int n);
		repeat (n) clock_cycle();
	endtask

	task automatic configure(input scan_mode_e m, input logic hires, input int blank_pct,
		input int wr_pct, input int c3_pct, input logic [7:0] code_mask);
		cfg_mode      = m;
		cfg_hires     = hires;
		cfg_blank_pct = blank_pct;
		cfg_wr_pct    = wr_pct;
		cfg_c3_pct    = c3_pct;
		cfg_code_mask = code_mask;
	endtask

	task automatic fill_palette(input int count, input logic sweep);
		fill_addr  = '0;
		fill_left  = count;
		fill_sweep = sweep;
		run_cycles(count);
	endtask

	initial
	begin
		void'($urandom(60912));
		rst_n = 1'b0;
		configure(SCAN_TV, 1'b0, 100, 0, 50, 8'hff);
		model_reset();
		drive_inputs();
		run_cycles(RESET_CYCLES);
		rst_n = 1'b1;
		// blanked while the whole palette gets its first contents
		configure(SCAN_VGA, 1'b0, 100, 0, 50, 8'hff);
		fill_palette(FILL_CYCLES, 1'b0);
		configure(SCAN_VGA, 1'b0, 0, 50, 50, 8'hff);
		run_cycles(MIX_CYCLES);
		configure(SCAN_VGA, 1'b1, 0, 10, 50, 8'hff);
		run_cycles(HIRES_CYCLES);
		configure(SCAN_TV, 1'b1, 0, 10, 50, 8'hff);
		run_cycles(HIRES_CYCLES);
		configure(SCAN_TV, 1'b0, 0, 0, 25, 8'hff);
		run_cycles(STROBE_CYCLES);
		configure(SCAN_VGA, 1'b0, 50, 20, 50, 8'hff);
		run_cycles(BLANK_CYCLES);
		configure(SCAN_TV, 1'b0, 50, 20, 50, 8'hff);
		run_cycles(BLANK_CYCLES);
		configure(SCAN_VGA, 1'b0, 100, 0, 50, 8'h1f);
		fill_palette(LOAD_CYCLES, 1'b1);
		// intensity and code sweep over entries 0 to 31
		configure(SCAN_TV, 1'b0, 0, 0, 50, 8'h1f);
		run_cycles(SWEEP_CYCLES);
		configure(SCAN_VGA, 1'b0, 0, 0, 50, 8'h1f);
		run_cycles(SWEEP_CYCLES);
		configure(SCAN_VGA, 1'b0, 100, 0, 0, 8'hff);
		run_cycles(FLUSH_CYCLES);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== logic/video_dac_top.sv ====
// pixel reaches dac two edges after sampling; timing generators and CPU clock live outside
`timescale 1ns/1ps

module video_dac_top
	import video_dac_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        c3,
	input  scan_mode_e  mode,
	input  logic [7:0]  tv_pix,
	input  logic [7:0]  vga_pix,
	input  logic        tv_blank,
	input  logic        vga_blank,
	input  logic        vga_line,
	input  logic [1:0]  nib_sel,
	input  logic        tv_hires,
	input  logic        vga_hires,
	input  palette_wr_t pal_wr,
	output dac_pair_t   dac
);

	logic [PAL_ADDR_W-1:0] pal_index;
	pixel_fetch_t          fetch;
	palette_word_t         pixel;

	// source select and index forming
	pixel_source_mux u_pixel_source_mux
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.c3        (c3),
		.mode      (mode),
		.tv_pix    (tv_pix),
		.vga_pix   (vga_pix),
		.tv_blank  (tv_blank),
		.vga_blank (vga_blank),
		.vga_line  (vga_line),
		.nib_sel   (nib_sel),
		.tv_hires  (tv_hires),
		.vga_hires (vga_hires),
		.pal_index (pal_index),
		.fetch     (fetch)
	);

	// colour lookup
	palette_ram #(
		.ADDR_W (PAL_ADDR_W),
		.DATA_W (PAL_DATA_W)
	) u_palette_ram
	(
		.clk     (clk),
		.pal_wr  (pal_wr),
		.rd_addr (pal_index),
		.pixel   (pixel)
	);

	// intensity dither to the DAC codes
	pwm_dither u_pwm_dither
	(
		.clk   (clk),
		.rst_n (rst_n),
		.pixel (pixel),
		.fetch (fetch),
		.dac   (dac)
	);

endmodule

// ==== logic/pwm_dither.sv ====
// dac holds two sub-samples per clock; the external clock-rate interleave is not part of this block
`timescale 1ns/1ps

module pwm_dither
	import video_dac_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  palette_word_t pixel,
	input  pixel_fetch_t  fetch,
	output dac_pair_t     dac
);

	pixel_fetch_t  fetch_q;
	palette_word_t vpix;
	logic [1:0]    ph_cnt;
	logic [1:0]    phase;
	logic [2:0]    bit0;
	logic [2:0]    bit1;
	dac_pair_t     dac_next;

	// one dithered sub-sample, code 3 saturates
	function automatic logic [1:0] dither_sub(
		input logic [1:0] code,
		input logic [2:0] inten,
		input logic [2:0] bit_num
	);
		logic [7:0] pat;
		pat = PWM_PATTERN[inten];
		if (!pat[bit_num] || (code == 2'd3))
			return code;
		else
			return code + 2'd1;
	endfunction

	// sideband delayed to line up with the RAM read
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			fetch_q <= '{blank: 1'b1, line: 1'b0, use_line: 1'b0};
		else
			fetch_q <= fetch;
	end

	// free-running phase counter
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ph_cnt <= '0;
		else
			ph_cnt <= ph_cnt + 2'd1;
	end

	// blanked pixels dither as all-zero
	assign vpix = fetch_q.blank ? '0 : pixel;

	// VGA takes the line bit, TV the counter msb
	assign phase = {fetch_q.use_line ? fetch_q.line : ph_cnt[1], ph_cnt[0]};
	assign bit0  = {phase, 1'b0};
	assign bit1  = {phase, 1'b1};

	always_comb
	begin
		dac_next.red0 = dither_sub(vpix.cred, vpix.ired, bit0);
		dac_next.grn0 = dither_sub(vpix.cgrn, vpix.igrn, bit0);
		dac_next.blu0 = dither_sub(vpix.cblu, vpix.iblu, bit0);
		dac_next.red1 = dither_sub(vpix.cred, vpix.ired, bit1);
		dac_next.grn1 = dither_sub(vpix.cgrn, vpix.igrn, bit1);
		dac_next.blu1 = dither_sub(vpix.cblu, vpix.iblu, bit1);
	end

	// output pair register
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			dac <= '0;
		else
			dac <= dac_next;
	end

endmodule

// ==== logic/palette_ram.sv ====
// contents are undefined until the CPU writes them; a read during a write gives old data
`timescale 1ns/1ps

module palette_ram
	import video_dac_pkg::*;
#(
	parameter int ADDR_W = 8,
	parameter int DATA_W = 15
)
(
	input  logic              clk,
	input  palette_wr_t       pal_wr,
	input  logic [ADDR_W-1:0] rd_addr,
	output palette_word_t     pixel
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// CPU write port
	always_ff @(posedge clk)
	begin
		if (pal_wr.we)
			mem[pal_wr.addr] <= pal_wr.data;
	end

	// video read port with one cycle latency
	always_ff @(posedge clk)
	begin
		pixel <= palette_word_t'(mem[rd_addr]);
	end

endmodule

// ==== logic/pixel_source_mux.sv ====
// TV pixels are taken only on c3 strobes; index and sideband leave one cycle after sampling
`timescale 1ns/1ps

module pixel_source_mux
	import video_dac_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  c3,
	input  scan_mode_e            mode,
	input  logic [7:0]            tv_pix,
	input  logic [7:0]            vga_pix,
	input  logic                  tv_blank,
	input  logic                  vga_blank,
	input  logic                  vga_line,
	input  logic [1:0]            nib_sel,
	input  logic                  tv_hires,
	input  logic                  vga_hires,
	output logic [PAL_ADDR_W-1:0] pal_index,
	output pixel_fetch_t          fetch
);

	logic [7:0]            tv_hold;
	logic [7:0]            src_pix;
	logic                  src_blank;
	logic                  src_hires;
	logic                  src_nib;
	logic [PAL_ADDR_W-1:0] index_next;
	pixel_fetch_t          fetch_next;

	// TV pixel hold, loaded on the strobe
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			tv_hold <= '0;
		else if (c3)
			tv_hold <= tv_pix;
	end

	// source selection by scan mode
	always_comb
	begin
		if (mode == SCAN_VGA)
		begin
			src_pix   = vga_pix;
			src_blank = vga_blank;
			src_hires = vga_hires;
			src_nib   = nib_sel[0];
		end
		else
		begin
			src_pix   = tv_hold;
			src_blank = tv_blank;
			src_hires = tv_hires;
			src_nib   = nib_sel[1];
		end
	end

	// hires maps one nibble into the top 16 palette entries
	always_comb
	begin
		if (src_hires)
			index_next = {4'b1111, src_nib ? src_pix[3:0] : src_pix[7:4]};
		else
			index_next = src_pix;

		fetch_next.blank    = src_blank;
		// TV line bit is unused
		fetch_next.line     = (mode == SCAN_VGA) ? vga_line : 1'b0;
		fetch_next.use_line = (mode == SCAN_VGA);
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pal_index <= '0;
			fetch     <= '{blank: 1'b1, line: 1'b0, use_line: 1'b0};
		end
		else
		begin
			pal_index <= index_next;
			fetch     <= fetch_next;
		end
	end

endmodule

// ==== logic/video_dac_pkg.sv ====
// shared types for the colour output stage; palette geometry is fixed at 256 x 15 bits
package video_dac_pkg;

	// palette geometry
	localparam int PAL_ADDR_W = 8;
	localparam int PAL_DATA_W = 15;

	// scan source selection
	typedef enum logic
	{
		SCAN_TV  = 1'b0,
		SCAN_VGA = 1'b1
	} scan_mode_e;

	// one colour RAM word, a 2-bit DAC code and a 3-bit intensity per channel
	typedef struct packed
	{
		logic [1:0] cred;
		logic [2:0] ired;
		logic [1:0] cgrn;
		logic [2:0] igrn;
		logic [1:0] cblu;
		logic [2:0] iblu;
	} palette_word_t;

	// sideband that travels beside the palette index
	typedef struct packed
	{
		logic blank;
		logic line;
		// set in VGA mode, phase high bit then comes from line
		logic use_line;
	} pixel_fetch_t;

	// CPU palette write port, completes in one cycle
	typedef struct packed
	{
		logic                  we;
		logic [PAL_ADDR_W-1:0] addr;
		logic [PAL_DATA_W-1:0] data;
	} palette_wr_t;

	// two DAC sub-samples per clock
	typedef struct packed
	{
		logic [1:0] red0;
		logic [1:0] grn0;
		logic [1:0] blu0;
		logic [1:0] red1;
		logic [1:0] grn1;
		logic [1:0] blu1;
	} dac_pair_t;

	// PWM patterns by intensity, bit 0 is the first sub-sample of phase 0
	localparam logic [7:0] PWM_PATTERN [8] = '{
		8'b00000000,
		8'b00000001,
		8'b01000001,
		8'b01000101,
		8'b10100101,
		8'b10100111,
		8'b11010111,
		8'b11011111
	};

endpackage
